/* hw/sample_buffer_pkg.sv */
// sample buffer shared definitions
// sizes, capture state encoding and the per-bank depth word

package sample_buffer_pkg;

  //////////////////////////////////////////////////////////////////////
  // sizes
  //////////////////////////////////////////////////////////////////////

  // input channels, one bank per channel
  localparam int channels = 4;
  // words per bank
  localparam int buffer_depth = 16;
  localparam int data_width = 16;
  // bank read register plus sequencer data stages
  localparam int read_latency = 2;

  localparam int addr_width = 4;
  // active channels = 1 << banking_mode
  localparam int mode_width = 2;
  // holds 0 to channels
  localparam int count_width = 3;
  localparam int bank_sel_width = 2;

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    IDLE,
    TRIGGER_WAIT,
    SAVE,
    HOLD
  } capture_state_t;

  // raw bank state as the bank keeps it
  typedef struct packed {
    logic                  full;
    logic [addr_width-1:0] addr;
  } bank_fields_t;

  // full with addr 0 reads back as buffer_depth when taken as a count
  typedef union packed {
    logic [addr_width:0] count;
    bank_fields_t        fields;
  } bank_depth_t;

endpackage

/* hw/capture_control.sv */
// capture controller
// gates start and stop pulses by state and runs the capture FSM

`timescale 1ns/1ns

module capture_control (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic capture_arm,
  input  logic sw_start,
  input  logic sw_stop,
  input  logic hw_start,
  input  logic hw_stop,
  input  logic capture_reset,
  input  logic chain_filled,
  input  logic readout_done,
  output logic start_pulse,
  output logic capture_active,
  output logic capture_idle,
  output logic capture_hold,
  output logic capture_done
);

  sample_buffer_pkg::capture_state_t state;
  logic stop_pulse;

  //////////////////////////////////////////////////////////////////////
  // start and stop gating
  //////////////////////////////////////////////////////////////////////

  assign capture_idle = (state == sample_buffer_pkg::IDLE);
  assign capture_hold = (state == sample_buffer_pkg::HOLD);

  // sw start works from idle or after arm, hw start needs arm first
  assign start_pulse = (sw_start & (capture_idle | (state == sample_buffer_pkg::TRIGGER_WAIT)))
                     | (hw_start & (state == sample_buffer_pkg::TRIGGER_WAIT));
  // stop only means something while saving
  assign stop_pulse = (sw_stop | hw_stop) & (state == sample_buffer_pkg::SAVE);

  //////////////////////////////////////////////////////////////////////
  // active flag and done pulse
  //////////////////////////////////////////////////////////////////////

  // set-reset flop gating every bank write
  always_ff @(posedge adc_clk) begin
    if (adc_reset || capture_reset) begin
      capture_active <= 1'b0;
    end else if (start_pulse) begin
      capture_active <= 1'b1;
    end else if (stop_pulse || chain_filled) begin
      capture_active <= 1'b0;
    end
  end

  // one cycle after the stop or the last write of the chain,
  // depth words are settled by then
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      capture_done <= 1'b0;
    end else begin
      capture_done <= stop_pulse | chain_filled;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // state machine
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset || capture_reset) begin
      state <= sample_buffer_pkg::IDLE;
    end else begin
      case (state)
        sample_buffer_pkg::IDLE: begin
          // a direct sw start wins over arm so state matches capture_active
          if (start_pulse) begin
            state <= sample_buffer_pkg::SAVE;
          end else if (capture_arm) begin
            state <= sample_buffer_pkg::TRIGGER_WAIT;
          end
        end
        sample_buffer_pkg::TRIGGER_WAIT: begin
          if (start_pulse) begin
            state <= sample_buffer_pkg::SAVE;
          end
        end
        sample_buffer_pkg::SAVE: begin
          if (stop_pulse || chain_filled) begin
            state <= sample_buffer_pkg::HOLD;
          end
        end
        sample_buffer_pkg::HOLD: begin
          // banks are drained, go back for the next capture
          if (readout_done) begin
            state <= sample_buffer_pkg::IDLE;
          end
        end
        default: state <= sample_buffer_pkg::IDLE;
      endcase
    end
  end

endmodule

/* hw/sample_router.sv */
// sample router
// maps channels onto banks for the banking mode and walks the write
// enable along each channel's chain of banks as they fill

`timescale 1ns/1ns

module sample_router (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0] adc_data,
  input  logic [sample_buffer_pkg::channels-1:0] adc_valid,
  input  logic [sample_buffer_pkg::mode_width-1:0] banking_mode,
  input  logic banking_mode_load,
  input  logic capture_idle,
  input  logic start_pulse,
  input  logic capture_active,
  input  logic capture_reset,
  input  logic readout_done,
  input  logic [sample_buffer_pkg::channels-1:0] bank_filled,
  output logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0] bank_data,
  output logic [sample_buffer_pkg::channels-1:0] bank_write,
  output logic chain_filled,
  output logic capture_full
);

  logic [sample_buffer_pkg::count_width-1:0] active_count;
  logic [sample_buffer_pkg::bank_sel_width-1:0] chan_mask;
  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0] data_d;
  logic [sample_buffer_pkg::channels-1:0] valid_d;
  logic [sample_buffer_pkg::channels-1:0] full_mask;
  logic [sample_buffer_pkg::channels-1:0] valid_mask;
  logic [sample_buffer_pkg::channels-1:0] fill_latch;

  //////////////////////////////////////////////////////////////////////
  // banking mode
  //////////////////////////////////////////////////////////////////////

  // only loaded in idle so routing never changes under a capture
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      active_count <= sample_buffer_pkg::count_width'(sample_buffer_pkg::channels);
    end else if (banking_mode_load && capture_idle) begin
      // modes beyond the channel count saturate at all channels
      if (int'(banking_mode) > $clog2(sample_buffer_pkg::channels)) begin
        active_count <= sample_buffer_pkg::count_width'(sample_buffer_pkg::channels);
      end else begin
        active_count <= sample_buffer_pkg::count_width'(1) << banking_mode;
      end
    end
  end

  // active count is a power of two, so bank mod active is a mask
  assign chan_mask = sample_buffer_pkg::bank_sel_width'(active_count - 1'b1);

  //////////////////////////////////////////////////////////////////////
  // masks
  //////////////////////////////////////////////////////////////////////

  // full mask marks the last bank of each chain, the top active banks
  always_comb begin
    for (int b = 0; b < sample_buffer_pkg::channels; b++) begin
      full_mask[b] = (b >= sample_buffer_pkg::channels - int'(active_count));
    end
  end

  // valid mask marks the bank each channel currently writes
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_mask <= '0;
    end else if (start_pulse) begin
      for (int b = 0; b < sample_buffer_pkg::channels; b++) begin
        valid_mask[b] <= (b < int'(active_count));
      end
    end else begin
      for (int b = 0; b < sample_buffer_pkg::channels; b++) begin
        if (bank_filled[b]) begin
          valid_mask[b] <= 1'b0;
          // hand over to the next bank of this chain, if there is one
          if (valid_mask[b] && (b + int'(active_count) < sample_buffer_pkg::channels)) begin
            valid_mask[b + int'(active_count)] <= 1'b1;
          end
        end
      end
    end
  end

  // bank fills since the last capture reset or readout
  always_ff @(posedge adc_clk) begin
    if (adc_reset || capture_reset || readout_done) begin
      fill_latch <= '0;
    end else begin
      fill_latch <= fill_latch | bank_filled;
    end
  end

  assign capture_full = |(full_mask & fill_latch);
  assign chain_filled = |(full_mask & bank_filled);

  //////////////////////////////////////////////////////////////////////
  // input stage and mux
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    data_d <= adc_data;
  end

  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_d <= '0;
    end else begin
      valid_d <= adc_valid;
    end
  end

  // bank b takes channel b mod active
  always_comb begin
    logic [sample_buffer_pkg::bank_sel_width-1:0] src;
    for (int b = 0; b < sample_buffer_pkg::channels; b++) begin
      src = sample_buffer_pkg::bank_sel_width'(b) & chan_mask;
      bank_data[b] = data_d[src];
      bank_write[b] = capture_active & valid_mask[b] & valid_d[src];
    end
  end

endmodule

/* hw/capture_bank.sv */
// one capture bank
// sample memory with its own write address, full latch and read register

`timescale 1ns/1ns

module capture_bank (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic write,
  input  logic [sample_buffer_pkg::data_width-1:0] write_data,
  input  logic clear,
  input  logic [sample_buffer_pkg::addr_width-1:0] read_addr,
  input  logic read_advance,
  output logic filled,
  output logic [sample_buffer_pkg::data_width-1:0] read_data,
  output sample_buffer_pkg::bank_depth_t depth
);

  logic [sample_buffer_pkg::data_width-1:0] mem [sample_buffer_pkg::buffer_depth];
  logic [sample_buffer_pkg::addr_width-1:0] write_addr;
  logic full;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // write landing on the top address fills the bank
  assign filled = write
                & (write_addr == sample_buffer_pkg::addr_width'(sample_buffer_pkg::buffer_depth - 1));

  always_ff @(posedge adc_clk) begin
    if (adc_reset || clear) begin
      write_addr <= '0;
      full <= 1'b0;
    end else begin
      if (write) begin
        // wraps to 0 on the last word, the latch keeps the count
        write_addr <= write_addr + 1'b1;
      end
      if (filled) begin
        full <= 1'b1;
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (write) begin
      mem[write_addr] <= write_data;
    end
  end

  // samples held so far
  assign depth.fields.full = full;
  assign depth.fields.addr = write_addr;

  //////////////////////////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////////////////////////

  // first read stage, frozen while the sequencer stalls
  always_ff @(posedge adc_clk) begin
    if (read_advance) begin
      read_data <= mem[read_addr];
    end
  end

endmodule

/* hw/readout_sequencer.sv */
// readout sequencer
// streams every bank in order over valid/ready/last through a read
// pipeline that freezes under back-pressure

`timescale 1ns/1ns

module readout_sequencer (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic readout_start,
  input  logic capture_hold,
  input  logic readout_ready,
  input  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0] bank_read_data,
  output logic [sample_buffer_pkg::addr_width-1:0] read_addr,
  output logic read_advance,
  output logic [sample_buffer_pkg::data_width-1:0] readout_data,
  output logic readout_valid,
  output logic readout_last,
  output logic readout_done
);

  logic [sample_buffer_pkg::bank_sel_width-1:0] bank_sel;
  logic active;
  logic busy;
  logic start_ok;
  logic at_last;
  logic [sample_buffer_pkg::read_latency-1:0] valid_pipe;
  logic [sample_buffer_pkg::read_latency-1:0] last_pipe;
  logic [sample_buffer_pkg::bank_sel_width-1:0] sel_pipe [sample_buffer_pkg::read_latency];
  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0]
    data_pipe [sample_buffer_pkg::read_latency-1];

  // the whole pipe moves only when the output is empty or taken
  assign read_advance = ~readout_valid | readout_ready;
  assign readout_done = readout_valid & readout_ready & readout_last;

  // a new readout needs held samples and a drained pipe
  assign start_ok = readout_start & capture_hold & ~busy;
  assign at_last = (read_addr == sample_buffer_pkg::addr_width'(sample_buffer_pkg::buffer_depth - 1))
                 & (bank_sel == sample_buffer_pkg::bank_sel_width'(sample_buffer_pkg::channels - 1));

  //////////////////////////////////////////////////////////////////////
  // address sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (adc_reset || start_ok) begin
      read_addr <= '0;
      bank_sel <= '0;
    end else if (active && read_advance) begin
      // address first, then bank
      read_addr <= read_addr + 1'b1;
      if (read_addr == sample_buffer_pkg::addr_width'(sample_buffer_pkg::buffer_depth - 1)) begin
        bank_sel <= bank_sel + 1'b1;
      end
    end
  end

  // active while issuing reads, busy until the last word is taken
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      active <= 1'b0;
      busy <= 1'b0;
    end else begin
      if (start_ok) begin
        active <= 1'b1;
      end else if (active && read_advance && at_last) begin
        active <= 1'b0;
      end
      if (start_ok) begin
        busy <= 1'b1;
      end else if (readout_done) begin
        busy <= 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read pipeline
  //////////////////////////////////////////////////////////////////////

  // stage 0 lines up with the bank read register
  always_ff @(posedge adc_clk) begin
    if (adc_reset) begin
      valid_pipe <= '0;
      last_pipe <= '0;
      for (int s = 0; s < sample_buffer_pkg::read_latency; s++) begin
        sel_pipe[s] <= '0;
      end
      readout_valid <= 1'b0;
      readout_last <= 1'b0;
    end else if (read_advance) begin
      valid_pipe <= {valid_pipe[sample_buffer_pkg::read_latency-2:0], active};
      last_pipe <= {last_pipe[sample_buffer_pkg::read_latency-2:0], active & at_last};
      sel_pipe[0] <= bank_sel;
      for (int s = 1; s < sample_buffer_pkg::read_latency; s++) begin
        sel_pipe[s] <= sel_pipe[s-1];
      end
      readout_valid <= valid_pipe[sample_buffer_pkg::read_latency-1];
      readout_last <= last_pipe[sample_buffer_pkg::read_latency-1];
    end
  end

  // data stages after the bank register, all banks carried side by side
  always_ff @(posedge adc_clk) begin
    if (read_advance) begin
      data_pipe[0] <= bank_read_data;
      for (int s = 1; s < sample_buffer_pkg::read_latency - 1; s++) begin
        data_pipe[s] <= data_pipe[s-1];
      end
      // bank select picks the word on its way into the output register
      readout_data <= data_pipe[sample_buffer_pkg::read_latency-2]
                               [sel_pipe[sample_buffer_pkg::read_latency-1]];
    end
  end

endmodule

/* hw/sample_buffer.sv */
// multi-bank sample capture buffer
// captures channels into chained banks, then drains them over one stream

`timescale 1ns/1ns

module sample_buffer (
  input  logic adc_clk,
  input  logic adc_reset,
  input  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0] adc_data,
  input  logic [sample_buffer_pkg::channels-1:0] adc_valid,
  // capture strobes
  input  logic capture_arm,
  input  logic sw_start,
  input  logic sw_stop,
  input  logic hw_start,
  input  logic hw_stop,
  input  logic capture_reset,
  input  logic [sample_buffer_pkg::mode_width-1:0] banking_mode,
  input  logic banking_mode_load,
  // status
  output logic capture_full,
  output logic capture_done,
  output sample_buffer_pkg::bank_depth_t [sample_buffer_pkg::channels-1:0] capture_depth,
  // readout stream
  input  logic readout_start,
  input  logic readout_ready,
  output logic [sample_buffer_pkg::data_width-1:0] readout_data,
  output logic readout_valid,
  output logic readout_last
);

  logic start_pulse;
  logic capture_active;
  logic capture_idle;
  logic capture_hold;
  logic chain_filled;
  logic readout_done;
  logic bank_clear;
  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0] bank_data;
  logic [sample_buffer_pkg::channels-1:0] bank_write;
  logic [sample_buffer_pkg::channels-1:0] bank_filled;
  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0] bank_read_data;
  logic [sample_buffer_pkg::addr_width-1:0] read_addr;
  logic read_advance;

  // a finished readout empties the banks for the next capture
  assign bank_clear = capture_reset | readout_done;

  capture_control capture_control_i (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .capture_arm(capture_arm),
    .sw_start(sw_start),
    .sw_stop(sw_stop),
    .hw_start(hw_start),
    .hw_stop(hw_stop),
    .capture_reset(capture_reset),
    .chain_filled(chain_filled),
    .readout_done(readout_done),
    .start_pulse(start_pulse),
    .capture_active(capture_active),
    .capture_idle(capture_idle),
    .capture_hold(capture_hold),
    .capture_done(capture_done)
  );

  sample_router sample_router_i (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .adc_data(adc_data),
    .adc_valid(adc_valid),
    .banking_mode(banking_mode),
    .banking_mode_load(banking_mode_load),
    .capture_idle(capture_idle),
    .start_pulse(start_pulse),
    .capture_active(capture_active),
    .capture_reset(capture_reset),
    .readout_done(readout_done),
    .bank_filled(bank_filled),
    .bank_data(bank_data),
    .bank_write(bank_write),
    .chain_filled(chain_filled),
    .capture_full(capture_full)
  );

  // one bank per channel, all sharing the read address
  for (genvar b = 0; b < sample_buffer_pkg::channels; b++) begin : g_bank
    capture_bank capture_bank_i (
      .adc_clk(adc_clk),
      .adc_reset(adc_reset),
      .write(bank_write[b]),
      .write_data(bank_data[b]),
      .clear(bank_clear),
      .read_addr(read_addr),
      .read_advance(read_advance),
      .filled(bank_filled[b]),
      .read_data(bank_read_data[b]),
      .depth(capture_depth[b])
    );
  end

  readout_sequencer readout_sequencer_i (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .readout_start(readout_start),
    .capture_hold(capture_hold),
    .readout_ready(readout_ready),
    .bank_read_data(bank_read_data),
    .read_addr(read_addr),
    .read_advance(read_advance),
    .readout_data(readout_data),
    .readout_valid(readout_valid),
    .readout_last(readout_last),
    .readout_done(readout_done)
  );

endmodule

/* bench/sample_buffer_tb.sv */
// sample buffer testbench
// random capture traffic against a reference model, checked by immediate assertions

`timescale 1ns/1ns

module sample_buffer_tb;

  // strobe masks for sample_cycle
  localparam logic [7:0] arm_p = 8'h01;
  localparam logic [7:0] sw_start_p = 8'h02;
  localparam logic [7:0] sw_stop_p = 8'h04;
  localparam logic [7:0] hw_start_p = 8'h08;
  localparam logic [7:0] hw_stop_p = 8'h10;
  localparam logic [7:0] reset_p = 8'h20;
  localparam logic [7:0] mode_load_p = 8'h40;
  localparam logic [7:0] readout_p = 8'h80;

  logic adc_clk;
  logic adc_reset;
  logic [sample_buffer_pkg::channels-1:0][sample_buffer_pkg::data_width-1:0] adc_data;
  logic [sample_buffer_pkg::channels-1:0] adc_valid;
  logic capture_arm;
  logic sw_start;
  logic sw_stop;
  logic hw_start;
  logic hw_stop;
  logic capture_reset;
  logic [sample_buffer_pkg::mode_width-1:0] banking_mode;
  logic banking_mode_load;
  logic capture_full;
  logic capture_done;
  sample_buffer_pkg::bank_depth_t [sample_buffer_pkg::channels-1:0] capture_depth;
  logic readout_start;
  logic readout_ready;
  logic [sample_buffer_pkg::data_width-1:0] readout_data;
  logic readout_valid;
  logic readout_last;

  logic [31:0] rng_state;

  // reference model of capture on/off, chain position per channel and bank contents
  bit model_on;
  int model_active;
  int cur_bank [sample_buffer_pkg::channels];
  int exp_cnt [sample_buffer_pkg::channels];
  logic [sample_buffer_pkg::data_width-1:0]
    exp_mem [sample_buffer_pkg::channels][sample_buffer_pkg::buffer_depth];

  sample_buffer dut (
    .adc_clk(adc_clk),
    .adc_reset(adc_reset),
    .adc_data(adc_data),
    .adc_valid(adc_valid),
    .capture_arm(capture_arm),
    .sw_start(sw_start),
    .sw_stop(sw_stop),
    .hw_start(hw_start),
    .hw_stop(hw_stop),
    .capture_reset(capture_reset),
    .banking_mode(banking_mode),
    .banking_mode_load(banking_mode_load),
    .capture_full(capture_full),
    .capture_done(capture_done),
    .capture_depth(capture_depth),
    .readout_start(readout_start),
    .readout_ready(readout_ready),
    .readout_data(readout_data),
    .readout_valid(readout_valid),
    .readout_last(readout_last)
  );

  initial begin
    adc_clk = 1'b0;
    forever #5 adc_clk = ~adc_clk;
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at first error");
  endtask

  task automatic stop_on_timeout(input string what);
    $display("timed out at %0t ns while waiting for %s", $time, what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped on timeout");
  endtask

  // banks are empty after reset, capture reset and every readout
  task automatic clear_model();
    for (int c = 0; c < sample_buffer_pkg::channels; c++) begin
      exp_cnt[c] = 0;
      cur_bank[c] = c;
    end
  endtask

  // drives one clock of strobes and random samples 1 ns after the edge and updates the model
  task automatic sample_cycle(input bit dense, input logic [7:0] pulses);
    logic [31:0] r;
    int b;
    bit chain_end;
    @(posedge adc_clk);
    #1;
    capture_arm = |(pulses & arm_p);
    sw_start = |(pulses & sw_start_p);
    sw_stop = |(pulses & sw_stop_p);
    hw_start = |(pulses & hw_start_p);
    hw_stop = |(pulses & hw_stop_p);
    capture_reset = |(pulses & reset_p);
    banking_mode_load = |(pulses & mode_load_p);
    readout_start = |(pulses & readout_p);
    // a start takes this cycle's samples, a stop already drops them
    if (|(pulses & (sw_start_p | hw_start_p))) begin
      model_on = 1'b1;
      clear_model();
    end
    if (|(pulses & (sw_stop_p | hw_stop_p | reset_p))) begin
      model_on = 1'b0;
    end
    if (|(pulses & reset_p)) begin
      clear_model();
    end
    chain_end = 1'b0;
    for (int c = 0; c < sample_buffer_pkg::channels; c++) begin
      rng_state = xorshift32(rng_state);
      r = rng_state;
      adc_data[c] = r[sample_buffer_pkg::data_width-1:0];
      adc_valid[c] = dense | r[16];
      if (model_on && adc_valid[c] && c < model_active) begin
        b = cur_bank[c];
        exp_mem[b][exp_cnt[b]] = adc_data[c];
        exp_cnt[b]++;
        // full bank hands over to the next bank of the chain, or ends capture
        if (exp_cnt[b] == sample_buffer_pkg::buffer_depth) begin
          if (b + model_active < sample_buffer_pkg::channels) begin
            cur_bank[c] = b + model_active;
          end else begin
            chain_end = 1'b1;
          end
        end
      end
    end
    if (chain_end) begin
      model_on = 1'b0;
    end
  endtask

  task automatic check_depths();
    for (int b = 0; b < sample_buffer_pkg::channels; b++) begin
      assert (int'(capture_depth[b].count) == exp_cnt[b])
        else stop_on_error($sformatf("bank %0d depth %0d, expected %0d",
                                     b, capture_depth[b].count, exp_cnt[b]));
    end
  endtask

  // watch_last keeps capture_full low until the top bank of a single chain fills
  task automatic wait_capture_done(input bit dense, input bit watch_last);
    int guard;
    guard = 0;
    while (!capture_done) begin
      sample_cycle(dense, 8'h00);
      if (watch_last && !capture_done) begin
        // the top bank's last write raises full and done on the same edge
        assert (!capture_full)
          else stop_on_error("capture_full high before the last bank of the chain filled");
      end
      guard++;
      if (guard > 400) begin
        stop_on_timeout("capture_done");
      end
    end
  endtask

  // drain every bank with random back-pressure and compare against the model
  task automatic read_all();
    int idx;
    int guard;
    int total;
    int b;
    int a;
    bit stalled;
    logic [sample_buffer_pkg::data_width-1:0] held;
    total = sample_buffer_pkg::channels * sample_buffer_pkg::buffer_depth;
    idx = 0;
    guard = 0;
    stalled = 1'b0;
    held = '0;
    sample_cycle(1'b0, readout_p);
    while (idx < total) begin
      sample_cycle(1'b0, 8'h00);
      readout_ready = (rng_state[9:8] != 2'b00);
      if (stalled) begin
        assert (readout_valid && readout_data == held)
          else stop_on_error("readout word changed while stalled");
      end
      stalled = 1'b0;
      if (readout_valid && readout_ready) begin
        b = idx / sample_buffer_pkg::buffer_depth;
        a = idx % sample_buffer_pkg::buffer_depth;
        // only written addresses have a known value
        if (a < exp_cnt[b]) begin
          assert (readout_data == exp_mem[b][a])
            else stop_on_error($sformatf("word %0d is %h, expected %h",
                                         idx, readout_data, exp_mem[b][a]));
        end
        assert (readout_last == (idx == total - 1))
          else stop_on_error($sformatf("readout_last wrong on word %0d", idx));
        idx++;
      end else if (readout_valid) begin
        stalled = 1'b1;
        held = readout_data;
      end
      guard++;
      if (guard > 1000) begin
        stop_on_timeout("the readout stream");
      end
    end
    sample_cycle(1'b0, 8'h00);
    assert (!readout_valid)
      else stop_on_error("extra word after the last one");
    // banks were cleared by the finished readout
    clear_model();
    check_depths();
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rng_state = 32'h5ddfc358;
    adc_reset = 1'b1;
    adc_data = '0;
    adc_valid = '0;
    capture_arm = 1'b0;
    sw_start = 1'b0;
    sw_stop = 1'b0;
    hw_start = 1'b0;
    hw_stop = 1'b0;
    capture_reset = 1'b0;
    banking_mode = '0;
    banking_mode_load = 1'b0;
    readout_start = 1'b0;
    readout_ready = 1'b0;
    model_on = 1'b0;
    model_active = sample_buffer_pkg::channels;
    clear_model();
    repeat (2) @(posedge adc_clk);
    #1;
    adc_reset = 1'b0;
    assert (!readout_valid && !readout_last && !capture_done && !capture_full)
      else stop_on_error("outputs not idle after reset");

    // all channels, every sample valid, so all banks fill together
    sample_cycle(1'b1, sw_start_p);
    wait_capture_done(1'b1, 1'b0);
    assert (capture_full) else stop_on_error("capture_full low after fill");
    check_depths();
    sample_cycle(1'b0, 8'h00);
    assert (!capture_done) else stop_on_error("capture_done longer than one cycle");
    read_all();

    // one active channel chained through all banks
    banking_mode = 2'd0;
    sample_cycle(1'b0, mode_load_p);
    model_active = 1;
    sample_cycle(1'b0, sw_start_p);
    wait_capture_done(1'b0, 1'b1);
    assert (capture_full) else stop_on_error("capture_full low after chain fill");
    check_depths();
    read_all();

    // arm, hardware start, hardware stop before any bank fills
    banking_mode = 2'd2;
    sample_cycle(1'b0, mode_load_p);
    model_active = sample_buffer_pkg::channels;
    sample_cycle(1'b0, arm_p);
    repeat (3) sample_cycle(1'b0, 8'h00);
    check_depths();
    sample_cycle(1'b0, hw_start_p);
    repeat (5) sample_cycle(1'b0, 8'h00);
    sample_cycle(1'b0, hw_stop_p);
    wait_capture_done(1'b0, 1'b0);
    check_depths();
    assert (!capture_full) else stop_on_error("capture_full high after early stop");
    read_all();

    // mode load during SAVE must not change the routing
    sample_cycle(1'b0, sw_start_p);
    repeat (3) sample_cycle(1'b0, 8'h00);
    banking_mode = 2'd0;
    sample_cycle(1'b0, mode_load_p);
    repeat (3) sample_cycle(1'b0, 8'h00);
    sample_cycle(1'b0, sw_stop_p);
    wait_capture_done(1'b0, 1'b0);
    check_depths();
    // capture reset from HOLD empties the banks
    sample_cycle(1'b0, reset_p);
    sample_cycle(1'b0, 8'h00);
    check_depths();
    // back in IDLE, a new capture still spreads over all channels
    sample_cycle(1'b0, sw_start_p);
    repeat (4) sample_cycle(1'b0, 8'h00);
    sample_cycle(1'b0, sw_stop_p);
    wait_capture_done(1'b0, 1'b0);
    check_depths();

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

/* bench/sample_buffer_sva.sv */
// sample buffer protocol properties
// readout handshake and capture done pulse, bound into the top level

`timescale 1ns/1ns

module sample_buffer_sva (
  input logic adc_clk,
  input logic adc_reset,
  input logic capture_done,
  input logic readout_valid,
  input logic readout_ready,
  input logic readout_last,
  input logic [sample_buffer_pkg::data_width-1:0] readout_data
);

  // a stalled word stays on the port until taken
  stall_hold: assert property (@(posedge adc_clk) disable iff (adc_reset)
    (readout_valid && !readout_ready) |=> (readout_valid && $stable(readout_data)))
    else $error("readout word not held under stall");

  last_has_valid: assert property (@(posedge adc_clk) disable iff (adc_reset)
    readout_last |-> readout_valid)
    else $error("readout_last without readout_valid");

  // done is a single pulse per capture
  done_pulse: assert property (@(posedge adc_clk) disable iff (adc_reset)
    capture_done |=> !capture_done)
    else $error("capture_done high for more than one cycle");

  // nothing streams straight out of reset
  reset_quiet: assert property (@(posedge adc_clk)
    adc_reset |=> !readout_valid)
    else $error("readout_valid high after reset");

endmodule

bind sample_buffer sample_buffer_sva sva_i (
  .adc_clk(adc_clk),
  .adc_reset(adc_reset),
  .capture_done(capture_done),
  .readout_valid(readout_valid),
  .readout_ready(readout_ready),
  .readout_last(readout_last),
  .readout_data(readout_data)
);

/* list.f */
hw/sample_buffer_pkg.sv
hw/capture_control.sv
hw/sample_router.sv
hw/capture_bank.sv
hw/readout_sequencer.sv
hw/sample_buffer.sv
bench/sample_buffer_tb.sv
bench/sample_buffer_sva.sv

/* run_sim.sh */
#!/bin/sh
# build the sample buffer testbench with Verilator and run it
# exit status is 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module sample_buffer_tb -f list.f -o sample_buffer_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sample_buffer_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1
